// File: files.f
common/core_types_pkg.sv
common/isa_pkg.sv
hw/instr_decoder.sv
datapath/register_file.sv
datapath/alu.sv
datapath/datapath.sv
hw/mem_access.sv
hw/cpu_core.sv
testbench/cpu_core_assert.sv
testbench/cpu_core_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := cpu_core_tb
FILE_LIST  := files.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG) || (echo "Run ended without a result, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/cpu_core_tb.sv
`timescale 1ns/100ps

module cpu_core_tb;

  localparam core_types_pkg::word_t nop_word  = {isa_pkg::op_nop, 28'd0};
  localparam core_types_pkg::word_t val_a     = 32'h80ff_7ff0; // Negative when signed.
  localparam core_types_pkg::word_t val_b     = 32'h7f01_80f8;
  localparam core_types_pkg::word_t st_addr   = 32'd8;
  localparam core_types_pkg::word_t copy_addr = 32'd20;

  logic                  reset_n;
  logic                  rst_n;
  core_types_pkg::word_t instr;
  core_types_pkg::word_t ld_data;
  core_types_pkg::word_t program_counter;
  core_types_pkg::word_t mem_addr;
  core_types_pkg::word_t st_data;
  logic                  st_en;
  logic                  ld_en;

  core_types_pkg::word_t imem [64];
  core_types_pkg::word_t dmem [64];
  core_types_pkg::word_t prog [$];
  core_types_pkg::word_t exp_addr [$];
  core_types_pkg::word_t exp_data [$];
  core_types_pkg::word_t exp_pc;
  core_types_pkg::word_t cur_instr;
  logic                  load_pending;
  logic                  exp_ld;
  int                    errors;
  int                    store_cnt;
  int                    cycles;
  int                    limit;

  cpu_core UUT (
    .reset_n         (reset_n),
    .rst_n           (rst_n),
    .instr           (instr),
    .ld_data         (ld_data),
    .program_counter (program_counter),
    .mem_addr        (mem_addr),
    .st_data         (st_data),
    .st_en           (st_en),
    .ld_en           (ld_en)
  );

  bind cpu_core cpu_core_assert u_cpu_core_assert (
    .reset_n (reset_n),
    .rst_n   (rst_n),
    .st_en   (st_en),
    .ld_en   (ld_en)
  );

  always #10 reset_n = ~reset_n;

  // Program starts at the reset address, anything outside reads as nop.
  function automatic core_types_pkg::word_t fetch(input core_types_pkg::word_t pc);
    core_types_pkg::word_t rel;
    rel = pc - core_types_pkg::pc_reset_value;
    if (rel < 32'd64) return imem[rel[5:0]];
    return nop_word;
  endfunction

  always_comb instr = fetch(program_counter);

  always @(posedge reset_n) begin
    if (st_en) dmem[mem_addr[5:0]] <= st_data;
    if (ld_en) ld_data <= dmem[mem_addr[5:0]]; // Answer one cycle later.
  end

  function automatic core_types_pkg::word_t lane_calc(
    input core_types_pkg::word_t x,
    input core_types_pkg::word_t y,
    input core_types_pkg::lane_t mode,
    input logic                  sub
  );
    core_types_pkg::word_t r;
    r = sub ? x - y : x + y;
    if (mode == core_types_pkg::lane_w16) begin
      for (int i = 0; i < 2; i++) begin
        r[16*i +: 16] = sub ? x[16*i +: 16] - y[16*i +: 16] : x[16*i +: 16] + y[16*i +: 16];
      end
    end else if (mode == core_types_pkg::lane_w8) begin
      for (int i = 0; i < 4; i++) begin
        r[8*i +: 8] = sub ? x[8*i +: 8] - y[8*i +: 8] : x[8*i +: 8] + y[8*i +: 8];
      end
    end
    return r;
  endfunction

  // Sum of the minterms selected by the table.
  function automatic core_types_pkg::word_t truth_calc(
    input core_types_pkg::word_t  x,
    input core_types_pkg::word_t  y,
    input core_types_pkg::truth_t tt
  );
    return ({32{tt[3]}} & x & y) | ({32{tt[2]}} & x & ~y) |
           ({32{tt[1]}} & ~x & y) | ({32{tt[0]}} & ~x & ~y);
  endfunction

  function automatic logic cond_holds(
    input isa_pkg::cmp_t         cc,
    input core_types_pkg::word_t x,
    input core_types_pkg::word_t y
  );
    case (cc)
      isa_pkg::cmp_eq:     return x == y;
      isa_pkg::cmp_ne:     return x != y;
      isa_pkg::cmp_lt:     return $signed(x) < $signed(y);
      isa_pkg::cmp_ge:     return !($signed(x) < $signed(y));
      isa_pkg::cmp_ltu:    return x < y;
      isa_pkg::cmp_geu:    return !(x < y);
      isa_pkg::cmp_always: return 1'b1;
      default:             return 1'b0;
    endcase
  endfunction

  function automatic core_types_pkg::word_t reg_value(input core_types_pkg::reg_idx_t idx);
    return (idx == 4'd1) ? val_a : val_b;
  endfunction

  task automatic emit_op(
    input isa_pkg::opcode_t         op,
    input core_types_pkg::reg_idx_t y1,
    input core_types_pkg::reg_idx_t a,
    input core_types_pkg::reg_idx_t b,
    input core_types_pkg::reg_idx_t c,
    input core_types_pkg::lane_t    ln,
    input isa_pkg::cmp_t            cc,
    input core_types_pkg::truth_t   tt
  );
    core_types_pkg::word_t w;
    w = '0;
    w[isa_pkg::op_hi:isa_pkg::op_lo]       = op;
    w[isa_pkg::y1_hi:isa_pkg::y1_lo]       = y1;
    w[isa_pkg::a_hi:isa_pkg::a_lo]         = a;
    w[isa_pkg::b_hi:isa_pkg::b_lo]         = b;
    w[isa_pkg::c_hi:isa_pkg::c_lo]         = c;
    w[isa_pkg::lane_hi:isa_pkg::lane_lo]   = ln;
    w[isa_pkg::cmp_hi:isa_pkg::cmp_lo]     = cc;
    w[isa_pkg::truth_hi:isa_pkg::truth_lo] = tt;
    prog.push_back(w);
  endtask

  task automatic emit_ldi(input core_types_pkg::reg_idx_t y1, input logic [23:0] v);
    prog.push_back({isa_pkg::op_ldi, y1, v});
  endtask

  task automatic emit_st(
    input core_types_pkg::reg_idx_t a,
    input core_types_pkg::reg_idx_t b,
    input core_types_pkg::word_t    addr,
    input core_types_pkg::word_t    data
  );
    emit_op(isa_pkg::op_st, 4'd0, a, b, 4'd0, core_types_pkg::lane_w32, isa_pkg::cmp_eq, 4'd0);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  // Full word from two halves, tmp is overwritten.
  task automatic load_const(
    input core_types_pkg::reg_idx_t dst,
    input core_types_pkg::reg_idx_t tmp,
    input core_types_pkg::word_t    v
  );
    emit_ldi(dst, {8'd0, v[31:16]});
    emit_op(isa_pkg::op_shl, dst, dst, 4'd15, 4'd0, 2'd0, isa_pkg::cmp_eq, 4'd0);
    emit_ldi(tmp, {8'd0, v[15:0]});
    emit_op(isa_pkg::op_logic, dst, dst, tmp, 4'd0, 2'd0, isa_pkg::cmp_eq, 4'b1110);
  endtask

  task automatic build_program();
    core_types_pkg::truth_t   tt_list [3];
    core_types_pkg::reg_idx_t ra;
    core_types_pkg::reg_idx_t rb;
    core_types_pkg::reg_idx_t rc;
    isa_pkg::cmp_t            cc;
    core_types_pkg::word_t    r8;
    core_types_pkg::word_t    target;
    logic [5:0]               la;
    // Store at the reset address, st_en must stay low until reset ends.
    emit_st(4'd1, 4'd0, 32'd0, core_types_pkg::pc_reset_value);
    emit_ldi(4'd15, 24'd16);
    emit_ldi(4'd14, st_addr[23:0]);
    load_const(4'd1, 4'd2, val_a);
    load_const(4'd2, 4'd3, val_b);
    for (int m = 0; m < 3; m++) begin
      emit_op(isa_pkg::op_add, 4'd4, 4'd1, 4'd2, 4'd0, m[1:0], isa_pkg::cmp_eq, 4'd0);
      emit_st(4'd14, 4'd4, st_addr, lane_calc(val_a, val_b, m[1:0], 1'b0));
      emit_op(isa_pkg::op_sub, 4'd4, 4'd1, 4'd2, 4'd0, m[1:0], isa_pkg::cmp_eq, 4'd0);
      emit_st(4'd14, 4'd4, st_addr, lane_calc(val_a, val_b, m[1:0], 1'b1));
    end
    emit_op(isa_pkg::op_addsub, 4'd5, 4'd1, 4'd2, 4'd6, 2'd0, isa_pkg::cmp_eq, 4'd0);
    emit_st(4'd14, 4'd5, st_addr, val_a + val_b);
    emit_st(4'd14, 4'd6, st_addr, val_a - val_b);
    tt_list[0] = 4'b1000; // And.
    tt_list[1] = 4'b0110; // Xor.
    tt_list[2] = 4'b0111; // Nand.
    for (int t = 0; t < 3; t++) begin
      emit_op(isa_pkg::op_logic, 4'd7, 4'd1, 4'd2, 4'd0, 2'd0, isa_pkg::cmp_eq, tt_list[t]);
      emit_st(4'd14, 4'd7, st_addr, truth_calc(val_a, val_b, tt_list[t]));
    end
    r8 = '0;
    for (int k = 0; k < 12; k++) begin
      ra = (k >= 10) ? 4'd2 : 4'd1;
      rb = (k < 8) ? 4'd2 : 4'd1;
      rc = k[0] ? 4'd2 : 4'd1;
      case (k)
        8:       cc = isa_pkg::cmp_eq;
        9:       cc = isa_pkg::cmp_ne;
        10:      cc = isa_pkg::cmp_lt;
        11:      cc = isa_pkg::cmp_ltu;
        default: cc = isa_pkg::cmp_t'(k[2:0]);
      endcase
      emit_op(isa_pkg::op_cmov, 4'd8, ra, rb, rc, 2'd0, cc, 4'd0);
      if (cond_holds(cc, reg_value(ra), reg_value(rb))) r8 = reg_value(rc);
      emit_st(4'd14, 4'd8, st_addr, r8);
    end
    la = {2'b11, 4'($urandom())}; // Upper quarter, never stored to.
    emit_ldi(4'd12, {18'd0, la});
    emit_op(isa_pkg::op_ld, 4'd11, 4'd12, 4'd0, 4'd0, 2'd0, isa_pkg::cmp_eq, 4'd0);
    emit_ldi(4'd13, copy_addr[23:0]);
    emit_st(4'd13, 4'd11, copy_addr, dmem[la]);
    target = core_types_pkg::pc_reset_value + 32'(prog.size()) + 32'd2;
    emit_ldi(4'd0, target[23:0]);
    emit_op(isa_pkg::op_st, 4'd0, 4'd14, 4'd5, 4'd0, 2'd0, isa_pkg::cmp_eq, 4'd0); // Skipped.
    emit_st(4'd14, 4'd2, st_addr, val_b);
  endtask

  task automatic report_mismatch(
    input string                 name,
    input core_types_pkg::word_t got,
    input core_types_pkg::word_t expected
  );
    errors++;
    $display("ERROR at %0t: %s got %h, expected %h", $time, name, got, expected);
  endtask

  always @(negedge reset_n) begin
    if (rst_n) begin
      cur_instr = fetch(exp_pc);
      exp_ld    = (cur_instr[isa_pkg::op_hi:isa_pkg::op_lo] == isa_pkg::op_ld) && !load_pending;
      if (program_counter !== exp_pc) begin
        report_mismatch("program_counter", program_counter, exp_pc);
      end
      if (ld_en !== exp_ld) begin
        report_mismatch("ld_en", {31'd0, ld_en}, {31'd0, exp_ld});
      end
      if (st_en) begin
        if (store_cnt >= exp_addr.size()) begin
          errors++;
          $display("Unexpected extra store at %0t to address %h", $time, mem_addr);
        end else begin
          if (mem_addr !== exp_addr[store_cnt]) begin
            report_mismatch("mem_addr", mem_addr, exp_addr[store_cnt]);
          end
          if (st_data !== exp_data[store_cnt]) begin
            report_mismatch("st_data", st_data, exp_data[store_cnt]);
          end
        end
        store_cnt++;
      end
      if (exp_ld) begin
        load_pending = 1'b1; // PC holds for the data cycle.
      end else begin
        load_pending = 1'b0;
        if (cur_instr[isa_pkg::op_hi:isa_pkg::op_lo] == isa_pkg::op_ldi &&
            cur_instr[isa_pkg::y1_hi:isa_pkg::y1_lo] == 4'd0) begin
          exp_pc = {8'd0, cur_instr[23:0]};
        end else begin
          exp_pc = exp_pc + 32'd1;
        end
      end
    end
  end

  initial begin
    reset_n      = 1'b0;
    rst_n        = 1'b0;
    ld_data      = '0;
    errors       = 0;
    store_cnt    = 0;
    load_pending = 1'b0;
    exp_pc       = core_types_pkg::pc_reset_value;
    void'($urandom(32'h7e98b286));
    for (int i = 0; i < 64; i++) begin
      dmem[i] = $urandom();
    end
    build_program();
    for (int i = 0; i < 64; i++) begin
      imem[i] = (i < prog.size()) ? prog[i] : nop_word;
    end
    limit = 2 * prog.size() + 50;
    repeat (2) @(posedge reset_n);
    rst_n <= 1'b1;
    cycles = 0;
    while (store_cnt < exp_addr.size() && cycles < limit) begin
      @(posedge reset_n);
      cycles++;
    end
    if (store_cnt < exp_addr.size()) begin
      errors++;
      $display("Timeout after %0d cycles with %0d of %0d stores seen",
               cycles, store_cnt, exp_addr.size());
    end
    $display("Stores checked: %0d of %0d, errors: %0d", store_cnt, exp_addr.size(), errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/cpu_core_assert.sv
`timescale 1ns/100ps

module cpu_core_assert (
  input reset_n,
  input rst_n,
  input st_en,
  input ld_en
);

  // One address bus serves both loads and stores.
  ld_st_exclusive: assert property (@(posedge reset_n) !(st_en && ld_en))
    else $error("st_en and ld_en high in the same cycle");

  // A load occupies the bus for one cycle only.
  ld_single_cycle: assert property (@(posedge reset_n) disable iff (!rst_n)
    ld_en |=> !ld_en)
    else $error("ld_en high in two consecutive cycles");

  strobes_quiet_in_reset: assert property (@(posedge reset_n)
    !rst_n |-> (!st_en && !ld_en))
    else $error("memory strobe high while rst_n is low");

endmodule

// File: hw/cpu_core.sv
`timescale 1ns/100ps

module cpu_core (
  input                         reset_n,
  input                         rst_n,
  input  core_types_pkg::word_t instr,
  input  core_types_pkg::word_t ld_data,
  output core_types_pkg::word_t program_counter,
  output core_types_pkg::word_t mem_addr,
  output core_types_pkg::word_t st_data,
  output logic                  st_en,
  output logic                  ld_en
);

  isa_pkg::opcode_t         op;
  core_types_pkg::reg_idx_t sel_a;
  core_types_pkg::reg_idx_t sel_b;
  core_types_pkg::reg_idx_t sel_c;
  core_types_pkg::reg_idx_t sel_y1;
  core_types_pkg::reg_idx_t sel_y2;
  core_types_pkg::lane_t    lane;
  core_types_pkg::truth_t   truth;
  isa_pkg::cmp_t            cmp;
  core_types_pkg::word_t    imm;
  core_types_pkg::word_t    op_a;
  core_types_pkg::word_t    op_b;
  logic                     wr_y1;
  logic                     wr_y2;
  logic                     is_ld;
  logic                     is_st;
  logic                     stall;
  logic                     ld_phase;

  instr_decoder u_instr_decoder (
    .instr  (instr),
    .op     (op),
    .sel_a  (sel_a),
    .sel_b  (sel_b),
    .sel_c  (sel_c),
    .sel_y1 (sel_y1),
    .sel_y2 (sel_y2),
    .lane   (lane),
    .truth  (truth),
    .cmp    (cmp),
    .imm    (imm),
    .wr_y1  (wr_y1),
    .wr_y2  (wr_y2),
    .is_ld  (is_ld),
    .is_st  (is_st)
  );

  datapath u_datapath (
    .reset_n         (reset_n),
    .rst_n           (rst_n),
    .op              (op),
    .sel_a           (sel_a),
    .sel_b           (sel_b),
    .sel_c           (sel_c),
    .sel_y1          (sel_y1),
    .sel_y2          (sel_y2),
    .lane            (lane),
    .truth           (truth),
    .cmp             (cmp),
    .imm             (imm),
    .wr_y1           (wr_y1),
    .wr_y2           (wr_y2),
    .stall           (stall),
    .ld_phase        (ld_phase),
    .ld_data         (ld_data),
    .op_a            (op_a),
    .op_b            (op_b),
    .program_counter (program_counter)
  );

  mem_access u_mem_access (
    .reset_n  (reset_n),
    .rst_n    (rst_n),
    .is_ld    (is_ld),
    .is_st    (is_st),
    .op_a     (op_a),
    .op_b     (op_b),
    .mem_addr (mem_addr),
    .st_data  (st_data),
    .st_en    (st_en),
    .ld_en    (ld_en),
    .stall    (stall),
    .ld_phase (ld_phase)
  );

endmodule

// File: hw/mem_access.sv
`timescale 1ns/100ps

module mem_access (
  input                         reset_n,
  input                         rst_n,
  input                         is_ld,
  input                         is_st,
  input  core_types_pkg::word_t op_a,
  input  core_types_pkg::word_t op_b,
  output core_types_pkg::word_t mem_addr,
  output core_types_pkg::word_t st_data,
  output logic                  st_en,
  output logic                  ld_en,
  output logic                  stall,
  output logic                  ld_phase
);

  typedef enum logic {
    idle,
    load_wait
  } state_t;

  state_t state;
  state_t state_nxt;

  always_ff @(posedge reset_n) begin
    if (!rst_n) begin
      state <= idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      idle:      if (is_ld) state_nxt = load_wait;
      load_wait: state_nxt = idle; // Data arrives this cycle.
      default:   state_nxt = idle;
    endcase
  end

  assign ld_en    = is_ld && (state == idle) && rst_n;
  assign stall    = ld_en; // Hold the PC while the read is out.
  assign ld_phase = (state == load_wait);
  assign st_en    = is_st && rst_n; // No strobes while in reset.

  assign mem_addr = op_a;
  assign st_data  = op_b;

endmodule

// File: datapath/datapath.sv
`timescale 1ns/100ps

module datapath (
  input                            reset_n,
  input                            rst_n,
  input  isa_pkg::opcode_t         op,
  input  core_types_pkg::reg_idx_t sel_a,
  input  core_types_pkg::reg_idx_t sel_b,
  input  core_types_pkg::reg_idx_t sel_c,
  input  core_types_pkg::reg_idx_t sel_y1,
  input  core_types_pkg::reg_idx_t sel_y2,
  input  core_types_pkg::lane_t    lane,
  input  core_types_pkg::truth_t   truth,
  input  isa_pkg::cmp_t            cmp,
  input  core_types_pkg::word_t    imm,
  input                            wr_y1,
  input                            wr_y2,
  input                            stall,
  input                            ld_phase,
  input  core_types_pkg::word_t    ld_data,
  output core_types_pkg::word_t    op_a,
  output core_types_pkg::word_t    op_b,
  output core_types_pkg::word_t    program_counter
);

  core_types_pkg::word_t val_c;
  core_types_pkg::word_t alu_y1;
  core_types_pkg::word_t alu_y2;
  core_types_pkg::word_t wd1;
  logic [7:0]            cmp_vec;
  logic                  cond_ok;
  logic                  we1;
  logic                  we2;

  assign cond_ok = (op != isa_pkg::op_cmov) || cmp_vec[cmp];
  assign we1     = wr_y1 && cond_ok && !stall;
  assign we2     = wr_y2 && !stall;
  assign wd1     = ld_phase ? ld_data : alu_y1; // Load result on second cycle.

  register_file u_register_file (
    .reset_n         (reset_n),
    .rst_n           (rst_n),
    .rd_a            (sel_a),
    .rd_b            (sel_b),
    .rd_c            (sel_c),
    .val_a           (op_a),
    .val_b           (op_b),
    .val_c           (val_c),
    .we1             (we1),
    .we2             (we2),
    .wa1             (sel_y1),
    .wa2             (sel_y2),
    .wd1             (wd1),
    .wd2             (alu_y2),
    .pc_adv          (!stall),
    .program_counter (program_counter)
  );

  alu u_alu (
    .op      (op),
    .lane    (lane),
    .truth   (truth),
    .a       (op_a),
    .b       (op_b),
    .c       (val_c),
    .imm     (imm),
    .y1      (alu_y1),
    .y2      (alu_y2),
    .cmp_vec (cmp_vec)
  );

endmodule

// File: datapath/alu.sv
`timescale 1ns/100ps

module alu (
  input  isa_pkg::opcode_t       op,
  input  core_types_pkg::lane_t  lane,
  input  core_types_pkg::truth_t truth,
  input  core_types_pkg::word_t  a,
  input  core_types_pkg::word_t  b,
  input  core_types_pkg::word_t  c,
  input  core_types_pkg::word_t  imm,
  output core_types_pkg::word_t  y1,
  output core_types_pkg::word_t  y2,
  output logic [7:0]             cmp_vec
);

  // Byte-wise add with the carry restarted at each lane boundary.
  function automatic core_types_pkg::word_t lane_arith(
    input core_types_pkg::word_t x,
    input core_types_pkg::word_t y,
    input logic                  sub,
    input core_types_pkg::lane_t mode
  );
    core_types_pkg::word_t y_eff;
    core_types_pkg::word_t res;
    logic                  carry;
    logic [8:0]            part;
    y_eff = sub ? ~y : y;
    carry = sub;
    for (int i = 0; i < 4; i++) begin
      if (mode == core_types_pkg::lane_w8 ||
          (mode == core_types_pkg::lane_w16 && i == 2)) begin
        carry = sub;
      end
      part = {1'b0, x[8*i +: 8]} + {1'b0, y_eff[8*i +: 8]} + {8'd0, carry};
      res[8*i +: 8] = part[7:0];
      carry = part[8];
    end
    return res;
  endfunction

  core_types_pkg::word_t logic_res;

  always_comb begin
    for (int i = 0; i < 32; i++) begin
      logic_res[i] = truth[{a[i], b[i]}];
    end
  end

  always_comb begin
    case (op)
      isa_pkg::op_add:    y1 = lane_arith(a, b, 1'b0, lane);
      isa_pkg::op_sub:    y1 = lane_arith(a, b, 1'b1, lane);
      isa_pkg::op_addsub: y1 = a + b;
      isa_pkg::op_logic:  y1 = logic_res;
      isa_pkg::op_shl:    y1 = a << b[4:0];
      isa_pkg::op_shr:    y1 = a >> b[4:0];
      isa_pkg::op_ldi:    y1 = imm;
      isa_pkg::op_cmov:   y1 = c;
      default:            y1 = '0;
    endcase
  end

  assign y2 = a - b; // Only written back for addsub.

  always_comb begin
    cmp_vec                      = '0;
    cmp_vec[isa_pkg::cmp_eq]     = (a == b);
    cmp_vec[isa_pkg::cmp_ne]     = (a != b);
    cmp_vec[isa_pkg::cmp_lt]     = ($signed(a) < $signed(b));
    cmp_vec[isa_pkg::cmp_ge]     = ($signed(a) >= $signed(b));
    cmp_vec[isa_pkg::cmp_ltu]    = (a < b);
    cmp_vec[isa_pkg::cmp_geu]    = (a >= b);
    cmp_vec[isa_pkg::cmp_always] = 1'b1;
    cmp_vec[isa_pkg::cmp_never]  = 1'b0;
  end

endmodule

// File: datapath/register_file.sv
`timescale 1ns/100ps

module register_file (
  input                            reset_n,
  input                            rst_n,
  input  core_types_pkg::reg_idx_t rd_a,
  input  core_types_pkg::reg_idx_t rd_b,
  input  core_types_pkg::reg_idx_t rd_c,
  output core_types_pkg::word_t    val_a,
  output core_types_pkg::word_t    val_b,
  output core_types_pkg::word_t    val_c,
  input                            we1,
  input                            we2,
  input  core_types_pkg::reg_idx_t wa1,
  input  core_types_pkg::reg_idx_t wa2,
  input  core_types_pkg::word_t    wd1,
  input  core_types_pkg::word_t    wd2,
  input                            pc_adv,
  output core_types_pkg::word_t    program_counter
);

  core_types_pkg::word_t regs [core_types_pkg::num_regs];
  logic                  pc_written;

  assign pc_written = (we1 && wa1 == '0) || (we2 && wa2 == '0);

  always_ff @(posedge reset_n) begin
    if (!rst_n) begin
      for (int i = 1; i < core_types_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
      regs[0] <= core_types_pkg::pc_reset_value;
    end else begin
      if (pc_adv && !pc_written) regs[0] <= regs[0] + 1'b1;
      if (we1) regs[wa1] <= wd1;
      if (we2) regs[wa2] <= wd2; // Port 2 wins on a clash.
    end
  end

  assign val_a           = regs[rd_a];
  assign val_b           = regs[rd_b];
  assign val_c           = regs[rd_c];
  assign program_counter = regs[0];

endmodule

// File: hw/instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder (
  input  core_types_pkg::word_t    instr,
  output isa_pkg::opcode_t         op,
  output core_types_pkg::reg_idx_t sel_a,
  output core_types_pkg::reg_idx_t sel_b,
  output core_types_pkg::reg_idx_t sel_c,
  output core_types_pkg::reg_idx_t sel_y1,
  output core_types_pkg::reg_idx_t sel_y2,
  output core_types_pkg::lane_t    lane,
  output core_types_pkg::truth_t   truth,
  output isa_pkg::cmp_t            cmp,
  output core_types_pkg::word_t    imm,
  output logic                     wr_y1,
  output logic                     wr_y2,
  output logic                     is_ld,
  output logic                     is_st
);

  logic [3:0] op_field;

  assign op_field = instr[isa_pkg::op_hi:isa_pkg::op_lo];

  always_comb begin
    case (op_field)
      isa_pkg::op_add,
      isa_pkg::op_sub,
      isa_pkg::op_addsub,
      isa_pkg::op_logic,
      isa_pkg::op_shl,
      isa_pkg::op_shr,
      isa_pkg::op_cmov,
      isa_pkg::op_ldi,
      isa_pkg::op_ld,
      isa_pkg::op_st,
      isa_pkg::op_nop: op = isa_pkg::opcode_t'(op_field);
      default:         op = isa_pkg::op_nop; // Unused codes do nothing.
    endcase
  end

  assign sel_y1 = instr[isa_pkg::y1_hi:isa_pkg::y1_lo];
  assign sel_a  = instr[isa_pkg::a_hi:isa_pkg::a_lo];
  assign sel_b  = instr[isa_pkg::b_hi:isa_pkg::b_lo];
  assign sel_c  = instr[isa_pkg::c_hi:isa_pkg::c_lo];
  assign sel_y2 = instr[isa_pkg::c_hi:isa_pkg::c_lo]; // Same field as c.
  assign lane   = instr[isa_pkg::lane_hi:isa_pkg::lane_lo];
  assign cmp    = isa_pkg::cmp_t'(instr[isa_pkg::cmp_hi:isa_pkg::cmp_lo]);
  assign truth  = instr[isa_pkg::truth_hi:isa_pkg::truth_lo];

  // Zero-extended immediate for ldi.
  assign imm = core_types_pkg::word_t'(instr[isa_pkg::imm_hi:isa_pkg::imm_lo]);

  always_comb begin
    wr_y1 = 1'b1;
    wr_y2 = 1'b0;
    case (op)
      isa_pkg::op_addsub: wr_y2 = 1'b1;
      isa_pkg::op_st,
      isa_pkg::op_nop:    wr_y1 = 1'b0;
      default:            ;
    endcase
  end

  assign is_ld = (op == isa_pkg::op_ld);
  assign is_st = (op == isa_pkg::op_st);

endmodule

// File: common/isa_pkg.sv
package isa_pkg;

  typedef enum logic [3:0] {
    op_add    = 4'd0,
    op_sub    = 4'd1,
    op_addsub = 4'd2,
    op_logic  = 4'd3,
    op_shl    = 4'd4,
    op_shr    = 4'd5,
    op_cmov   = 4'd6,
    op_ldi    = 4'd7,
    op_ld     = 4'd8,
    op_st     = 4'd9,
    op_nop    = 4'd10
  } opcode_t;

  // Bit positions in the compare vector.
  typedef enum logic [2:0] {
    cmp_eq     = 3'd0,
    cmp_ne     = 3'd1,
    cmp_lt     = 3'd2,
    cmp_ge     = 3'd3,
    cmp_ltu    = 3'd4,
    cmp_geu    = 3'd5,
    cmp_always = 3'd6,
    cmp_never  = 3'd7
  } cmp_t;

  localparam int op_hi    = 31;
  localparam int op_lo    = 28;
  localparam int y1_hi    = 27;
  localparam int y1_lo    = 24;
  localparam int a_hi     = 23;
  localparam int a_lo     = 20;
  localparam int b_hi     = 19;
  localparam int b_lo     = 16;
  localparam int c_hi     = 15; // Shared by c and y2.
  localparam int c_lo     = 12;
  localparam int lane_hi  = 11;
  localparam int lane_lo  = 10;
  localparam int cmp_hi   = 9;
  localparam int cmp_lo   = 7;
  localparam int truth_hi = 3;
  localparam int truth_lo = 0;
  localparam int imm_hi   = 23;
  localparam int imm_lo   = 0;

endpackage

// File: common/core_types_pkg.sv
package core_types_pkg;

  localparam int word_width = 32;
  localparam int num_regs   = 16;

  // Data and address word.
  typedef logic [word_width-1:0] word_t;

  // Register index.
  typedef logic [3:0] reg_idx_t;

  // Lane mode, 3 behaves like a single 32-bit lane.
  typedef logic [1:0] lane_t;

  // Logic truth table, indexed by {a_bit, b_bit}.
  typedef logic [3:0] truth_t;

  localparam lane_t lane_w32 = 2'd0;
  localparam lane_t lane_w16 = 2'd1;
  localparam lane_t lane_w8  = 2'd2;

  // Program counter after reset.
  localparam word_t pc_reset_value = 32'd16;

endpackage
